/* Bender.yml */
package:
  name: mem_pipe_slice

sources:
  - files:
      - logic/memPipePkg.sv
      - logic/memIssueStage.sv
      - logic/physRegFile.sv
      - logic/memRegisterReadStage.sv
      - logic/memAddressStage.sv
      - logic/memPipeTop.sv
  - target: test
    files:
      - tests/memPipeClock.sv
      - tests/memRegisterReadStage_assertions.sv
      - tests/memPipeTb.sv

/* logic/memAddressStage.sv */
/*
 * Address stage of the memory pipeline.
 * Adds the sign-extended offset to operand A and registers
 * one memory request per lane.
 */
`timescale 1ns/1ps

module memAddressStage (
    input  logic clk,
    input  logic rstN,
    input  memPipePkg::rrResult rrOut [memPipePkg::memIssueWidth],
    output memPipePkg::memRequest memReqs [memPipePkg::memIssueWidth]
);
    import memPipePkg::*;

    logic [dataWidth-1:0] offsetExt [memIssueWidth];
    memRequest nextReq [memIssueWidth];

    always_comb begin
        for (int i = 0; i < memIssueWidth; i++) begin
            offsetExt[i] = {
                {(dataWidth - offsetWidth){rrOut[i].op.offset[offsetWidth-1]}},
                rrOut[i].op.offset
            };
        end
    end

    always_comb begin
        for (int i = 0; i < memIssueWidth; i++) begin
            nextReq[i].valid = rrOut[i].valid;
            nextReq[i].opKind = rrOut[i].op.opKind;
            nextReq[i].address = rrOut[i].operandA.data + offsetExt[i];
            // Operand B is the store payload
            nextReq[i].storeData = rrOut[i].operandB.data;
            nextReq[i].dstReg = rrOut[i].op.dstReg;
            nextReq[i].ready = rrOut[i].operandA.ready && rrOut[i].operandB.ready;
        end
    end

    // Loaded every cycle, stalls arrive here as bubbles
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < memIssueWidth; i++) begin
                memReqs[i].valid <= 1'b0;
            end
        end else begin
            memReqs <= nextReq;
        end
    end

endmodule

/* logic/memIssueStage.sv */
/*
 * Issue stage of the memory pipeline.
 * Registers up to two ops per cycle and stamps each valid op
 * with an active-list pointer from a wrapping counter.
 */
`timescale 1ns/1ps

module memIssueStage (
    input  logic clk,
    input  logic rstN,
    input  logic stall,
    input  logic clear,
    input  memPipePkg::memOp issueOps [memPipePkg::memIssueWidth],
    output memPipePkg::memOp issueOut [memPipePkg::memIssueWidth]
);
    import memPipePkg::*;

    memOp stamped [memIssueWidth];
    activeListPtr nextPtr;
    activeListPtr ptrAfter;

    // Lane 0 takes the first pointer, lane 1 the following one
    always_comb begin : stampPtr
        activeListPtr ptr;
        ptr = nextPtr;
        for (int i = 0; i < memIssueWidth; i++) begin
            stamped[i] = issueOps[i];
            stamped[i].listPtr = ptr;
            if (issueOps[i].valid) begin
                ptr = ptr + 1'b1;
            end
        end
        // Counter value once this cycle's ops are accepted
        ptrAfter = ptr;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            nextPtr <= '0;
            for (int i = 0; i < memIssueWidth; i++) begin
                issueOut[i].valid <= 1'b0;
            end
        end else if (!stall) begin
            for (int i = 0; i < memIssueWidth; i++) begin
                issueOut[i] <= stamped[i];
                if (clear) begin
                    issueOut[i].valid <= 1'b0;
                end
            end
            // Cleared ops never consume pointers
            if (!clear) begin
                nextPtr <= ptrAfter;
            end
        end
    end

endmodule

/* logic/memPipePkg.sv */
/*
 * Shared definitions for the two-lane memory pipeline slice.
 * Widths and lane count, operand and op kinds, stage records
 * and the selective flush range check.
 */
package memPipePkg;

    localparam int memIssueWidth = 2;
    localparam int readPortNum = 2 * memIssueWidth;
    localparam int dataWidth = 32;
    localparam int offsetWidth = 12;
    localparam int physRegNum = 64;
    localparam int activeListPtrWidth = 5;
    localparam int mshrNum = 4;

    typedef logic [$clog2(physRegNum)-1:0] physRegIdx;
    typedef logic [activeListPtrWidth-1:0] activeListPtr;
    typedef logic [$clog2(mshrNum)-1:0] mshrIdx;

    typedef enum logic [1:0] {
        operandReg = 2'd0,
        operandImm = 2'd1,
        operandPc  = 2'd2
    } operandKind;

    typedef enum logic {
        memLoad  = 1'b0,
        memStore = 1'b1
    } memOpKind;

    // Memory micro-op as it leaves the issue stage
    typedef struct packed {
        logic valid;
        memOpKind opKind;
        operandKind operandKindA;
        operandKind operandKindB;
        physRegIdx srcRegA;
        physRegIdx srcRegB;
        physRegIdx dstReg;
        logic writesReg;
        logic [dataWidth-1:0] pc;
        logic [offsetWidth-1:0] offset;
        logic hasMshr;
        mshrIdx mshrId;
        activeListPtr listPtr;
    } memOp;

    typedef struct packed {
        logic [dataWidth-1:0] data;
        logic ready;
    } operandWord;

    typedef struct packed {
        logic valid;
        memOp op;
        operandWord operandA;
        operandWord operandB;
    } rrResult;

    typedef struct packed {
        logic valid;
        memOpKind opKind;
        logic [dataWidth-1:0] address;
        logic [dataWidth-1:0] storeData;
        physRegIdx dstReg;
        logic ready;
    } memRequest;

    // Recovery range, head inclusive and tail exclusive
    typedef struct packed {
        logic active;
        activeListPtr headPtr;
        activeListPtr tailPtr;
    } flushRange;

    function automatic logic inFlushRange(flushRange recovery, activeListPtr ptr);
        activeListPtr distance;
        activeListPtr span;
        // Wrapping distances from the head
        distance = ptr - recovery.headPtr;
        span = recovery.tailPtr - recovery.headPtr;
        return recovery.active && (distance < span);
    endfunction

endpackage

/* logic/memPipeTop.sv */
/*
 * Memory pipeline slice top level.
 * Issue, register-read and address stages around the register file.
 */
`timescale 1ns/1ps

module memPipeTop (
    input  logic clk,
    input  logic rstN,
    input  logic stall,
    input  logic clear,
    input  memPipePkg::flushRange recovery,
    input  memPipePkg::memOp issueOps [memPipePkg::memIssueWidth],
    input  logic regWriteEn,
    input  memPipePkg::physRegIdx regWriteIdx,
    input  logic [memPipePkg::dataWidth-1:0] regWriteData,
    output memPipePkg::memRequest memReqs [memPipePkg::memIssueWidth],
    output logic [memPipePkg::mshrNum-1:0] mshrRelease
);
    import memPipePkg::*;

    memOp issueOut [memIssueWidth];
    physRegIdx readIdx [readPortNum];
    operandWord readData [readPortNum];
    rrResult rrOut [memIssueWidth];

    memIssueStage issueStage (
        .clk(clk),
        .rstN(rstN),
        .stall(stall),
        .clear(clear),
        .issueOps(issueOps),
        .issueOut(issueOut)
    );

    physRegFile regFile (
        .clk(clk),
        .rstN(rstN),
        .writeEn(regWriteEn),
        .writeIdx(regWriteIdx),
        .writeData(regWriteData),
        .readIdx(readIdx),
        .readData(readData)
    );

    memRegisterReadStage registerReadStage (
        .clk(clk),
        .rstN(rstN),
        .stall(stall),
        .clear(clear),
        .recovery(recovery),
        .issueOut(issueOut),
        .readData(readData),
        .readIdx(readIdx),
        .rrOut(rrOut),
        .mshrRelease(mshrRelease)
    );

    memAddressStage addressStage (
        .clk(clk),
        .rstN(rstN),
        .rrOut(rrOut),
        .memReqs(memReqs)
    );

endmodule

/* logic/memRegisterReadStage.sv */
/*
 * Register-read stage of the memory pipeline.
 * Pipeline register, source reads and operand select,
 * selective flush and miss-entry release for flushed loads.
 */
`timescale 1ns/1ps

module memRegisterReadStage (
    input  logic clk,
    input  logic rstN,
    input  logic stall,
    input  logic clear,
    input  memPipePkg::flushRange recovery,
    input  memPipePkg::memOp issueOut [memPipePkg::memIssueWidth],
    input  memPipePkg::operandWord readData [memPipePkg::readPortNum],
    output memPipePkg::physRegIdx readIdx [memPipePkg::readPortNum],
    output memPipePkg::rrResult rrOut [memPipePkg::memIssueWidth],
    output logic [memPipePkg::mshrNum-1:0] mshrRelease
);
    import memPipePkg::*;

    memOp pipeReg [memIssueWidth];
    logic flush [memIssueWidth];

    // Immediate is always zero for loads and stores
    function automatic operandWord selectOperand(
        operandKind kind,
        operandWord regWord,
        logic [dataWidth-1:0] pc
    );
        operandWord result;
        case (kind)
            operandImm: begin
                result.data = '0;
                result.ready = 1'b1;
            end
            operandPc: begin
                result.data = pc;
                result.ready = 1'b1;
            end
            default: begin
                result = regWord;
            end
        endcase
        return result;
    endfunction

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < memIssueWidth; i++) begin
                pipeReg[i].valid <= 1'b0;
            end
        end else if (!stall) begin
            pipeReg <= issueOut;
        end
    end

    // Two read ports per lane, A on the even port
    always_comb begin
        for (int i = 0; i < memIssueWidth; i++) begin
            readIdx[2*i] = pipeReg[i].srcRegA;
            readIdx[2*i+1] = pipeReg[i].srcRegB;
        end
    end

    always_comb begin
        for (int i = 0; i < memIssueWidth; i++) begin
            flush[i] = inFlushRange(recovery, pipeReg[i].listPtr);

            rrOut[i].op = pipeReg[i];
            rrOut[i].operandA = selectOperand(
                pipeReg[i].operandKindA,
                readData[2*i],
                pipeReg[i].pc
            );
            rrOut[i].operandB = selectOperand(
                pipeReg[i].operandKindB,
                readData[2*i+1],
                pipeReg[i].pc
            );

            // Killed ops leave as bubbles
            if (stall || clear || !rstN || flush[i]) begin
                rrOut[i].valid = 1'b0;
            end else begin
                rrOut[i].valid = pipeReg[i].valid;
            end
        end
    end

    // A flushed load gives back its miss entry
    always_comb begin
        mshrRelease = '0;
        for (int i = 0; i < memIssueWidth; i++) begin
            if (pipeReg[i].valid && flush[i] && pipeReg[i].opKind == memLoad &&
                    pipeReg[i].hasMshr) begin
                mshrRelease[pipeReg[i].mshrId] = 1'b1;
            end
        end
    end

endmodule

/* logic/physRegFile.sv */
/*
 * Physical register file with a ready bit per register.
 * One write port and four asynchronous read ports.
 */
`timescale 1ns/1ps

module physRegFile (
    input  logic clk,
    input  logic rstN,
    input  logic writeEn,
    input  memPipePkg::physRegIdx writeIdx,
    input  logic [memPipePkg::dataWidth-1:0] writeData,
    input  memPipePkg::physRegIdx readIdx [memPipePkg::readPortNum],
    output memPipePkg::operandWord readData [memPipePkg::readPortNum]
);
    import memPipePkg::*;

    logic [dataWidth-1:0] regData [physRegNum];
    logic [physRegNum-1:0] regReady;

    // Storage array
    always_ff @(posedge clk) begin
        if (writeEn) begin
            regData[writeIdx] <= writeData;
        end
    end

    // Nothing is ready until it has been written once
    always_ff @(posedge clk) begin
        if (!rstN) begin
            regReady <= '0;
        end else if (writeEn) begin
            regReady[writeIdx] <= 1'b1;
        end
    end

    always_comb begin
        for (int p = 0; p < readPortNum; p++) begin
            readData[p].data = regData[readIdx[p]];
            readData[p].ready = regReady[readIdx[p]];
        end
    end

endmodule

/* src.f */
logic/memPipePkg.sv
logic/memIssueStage.sv
logic/physRegFile.sv
logic/memRegisterReadStage.sv
logic/memAddressStage.sv
logic/memPipeTop.sv
tests/memPipeClock.sv
tests/memRegisterReadStage_assertions.sv
tests/memPipeTb.sv

/* tests/memPipeClock.sv */
/*
 * Testbench clock and reset generator.
 * 100 ns clock, reset held low for two rising edges.
 */
`timescale 1ns/1ps

module memPipeClock (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Released just after the second edge, like any other input
    initial begin
        rstN = 1'b0;
        repeat (2) @(posedge clk);
        #5;
        rstN = 1'b1;
    end

endmodule

/* tests/memPipeTb.sv */
/*
 * Testbench top for the memory pipeline slice.
 * Directed stimulus per behavior, a reference model of the three
 * stages checked against memReqs, and a cycle limit.
 */
`timescale 1ns/1ps

module memPipeTb;
    import memPipePkg::*;

    localparam int cycleLimit = 400;

    logic clk;
    logic rstN;
    logic stall;
    logic clear;
    flushRange recovery;
    memOp issueOps [memIssueWidth];
    logic regWriteEn;
    physRegIdx regWriteIdx;
    logic [dataWidth-1:0] regWriteData;
    memRequest memReqs [memIssueWidth];
    logic [mshrNum-1:0] mshrRelease;

    // Reference model state
    memOp issueModel [memIssueWidth];
    memOp rrModel [memIssueWidth];
    memRequest reqModel [memIssueWidth];
    activeListPtr ptrModel;
    logic [dataWidth-1:0] regValue [physRegNum];
    logic [physRegNum-1:0] regReady;
    string testName;
    int cycleCount;

    memPipeClock clockGen (.clk(clk), .rstN(rstN));

    memPipeTop DUT (
        .clk(clk),
        .rstN(rstN),
        .stall(stall),
        .clear(clear),
        .recovery(recovery),
        .issueOps(issueOps),
        .regWriteEn(regWriteEn),
        .regWriteIdx(regWriteIdx),
        .regWriteData(regWriteData),
        .memReqs(memReqs),
        .mshrRelease(mshrRelease)
    );

    bind memRegisterReadStage memRegisterReadStage_assertions rrChecks (
        .clk(clk),
        .rstN(rstN),
        .stall(stall),
        .recovery(recovery),
        .rrOut(rrOut),
        .mshrRelease(mshrRelease)
    );

    // Head inclusive, tail exclusive, range may wrap past 31
    function automatic logic ptrCovered(flushRange flushIn, activeListPtr ptr);
        if (!flushIn.active) begin
            return 1'b0;
        end
        if (flushIn.headPtr <= flushIn.tailPtr) begin
            return ptr >= flushIn.headPtr && ptr < flushIn.tailPtr;
        end
        return ptr >= flushIn.headPtr || ptr < flushIn.tailPtr;
    endfunction

    function automatic operandWord modelOperand(operandKind kind, physRegIdx idx,
            logic [dataWidth-1:0] pc);
        operandWord word;
        word.data = (kind == operandPc) ? pc : (kind == operandImm) ? 32'd0 : regValue[idx];
        word.ready = (kind == operandReg) ? regReady[idx] : 1'b1;
        return word;
    endfunction

    function automatic memOp makeOp(memOpKind kind, operandKind kindA, operandKind kindB,
            physRegIdx regA, physRegIdx regB, logic [offsetWidth-1:0] offset);
        memOp op;
        op = '0;
        op.valid = 1'b1;
        op.opKind = kind;
        op.operandKindA = kindA;
        op.operandKindB = kindB;
        op.srcRegA = regA;
        op.srcRegB = regB;
        op.dstReg = physRegIdx'($urandom);
        op.writesReg = (kind == memLoad);
        op.pc = $urandom & 32'hffff_fffc;
        op.offset = offset;
        return op;
    endfunction

    task automatic failRun();
        $display("test failed");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic reportMismatch(int lane, string field, logic [127:0] expected,
            logic [127:0] actual);
        $display("** Error [%s] lane %0d %s: expected %0h, actual %0h",
            testName, lane, field, expected, actual);
        failRun();
    endtask

    // Next state of every stage at a rising edge, from the inputs of the cycle
    task automatic modelEdge();
        operandWord opA;
        operandWord opB;
        for (int i = 0; i < memIssueWidth; i++) begin
            opA = modelOperand(rrModel[i].operandKindA, rrModel[i].srcRegA, rrModel[i].pc);
            opB = modelOperand(rrModel[i].operandKindB, rrModel[i].srcRegB, rrModel[i].pc);
            reqModel[i].valid = rrModel[i].valid && !stall && !clear &&
                !ptrCovered(recovery, rrModel[i].listPtr);
            reqModel[i].opKind = rrModel[i].opKind;
            reqModel[i].address = opA.data + dataWidth'($signed(rrModel[i].offset));
            reqModel[i].storeData = opB.data;
            reqModel[i].dstReg = rrModel[i].dstReg;
            reqModel[i].ready = opA.ready && opB.ready;
        end
        if (!stall) begin
            rrModel = issueModel;
            for (int i = 0; i < memIssueWidth; i++) begin
                issueModel[i] = issueOps[i];
                issueModel[i].listPtr = ptrModel;
                issueModel[i].valid = issueOps[i].valid && !clear;
                if (issueModel[i].valid) begin
                    ptrModel++;
                end
            end
        end
        if (regWriteEn) begin
            regValue[regWriteIdx] = regWriteData;
            regReady[regWriteIdx] = 1'b1;
        end
    endtask

    // Unknown data of unwritten registers is left out, ready still counts
    task automatic checkReqs();
        for (int i = 0; i < memIssueWidth; i++) begin
            if (memReqs[i].valid !== reqModel[i].valid) begin
                reportMismatch(i, "valid", reqModel[i].valid, memReqs[i].valid);
            end else if (reqModel[i].valid && reqModel[i].ready && memReqs[i] !== reqModel[i]) begin
                reportMismatch(i, "request", reqModel[i], memReqs[i]);
            end else if (reqModel[i].valid && memReqs[i].ready !== reqModel[i].ready) begin
                reportMismatch(i, "ready", reqModel[i].ready, memReqs[i].ready);
            end
        end
    endtask

    // One clock, outputs sampled 5 ns after the edge, then pulses dropped
    task automatic runCycle();
        @(posedge clk);
        modelEdge();
        #5;
        checkReqs();
        if (DUT.registerReadStage.rrChecks.failCount != 0) begin
            $display("A bound assertion on the register-read stage failed");
            failRun();
        end
        for (int i = 0; i < memIssueWidth; i++) begin
            issueOps[i] = '0;
        end
        regWriteEn = 1'b0;
        clear = 1'b0;
        recovery.active = 1'b0;
    endtask

    task automatic issuePair(memOp op0, memOp op1);
        issueOps[0] = op0;
        issueOps[1] = op1;
        runCycle();
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Cycle limit of %0d reached before the tests finished", cycleLimit);
            failRun();
        end
    end

    initial begin
        memOp loadOp;
        memOp storeOp;
        void'($urandom(32'h0f7b_1c0e));
        cycleCount = 0;
        stall = 1'b0;
        clear = 1'b0;
        recovery = '0;
        regWriteEn = 1'b0;
        regWriteIdx = '0;
        regWriteData = '0;
        ptrModel = '0;
        regReady = '0;
        for (int i = 0; i < memIssueWidth; i++) begin
            issueOps[i] = '0;
            issueModel[i] = '0;
            rrModel[i] = '0;
            reqModel[i] = '0;
        end
        @(posedge rstN);

        testName = "registerOperands";
        for (int r = 1; r <= 8; r++) begin
            regWriteEn = 1'b1;
            regWriteIdx = physRegIdx'(r);
            regWriteData = $urandom;
            runCycle();
        end
        issuePair(makeOp(memLoad, operandReg, operandImm, 1, 0, 12'h010),
            makeOp(memStore, operandReg, operandReg, 2, 3, 12'hff8));
        issuePair(makeOp(memStore, operandReg, operandReg, 4, 5, 12'h7fc),
            makeOp(memLoad, operandReg, operandImm, 6, 0, 12'h800));
        repeat (3) runCycle();

        // Registers 40 and 41 are never written
        testName = "operandKinds";
        issuePair(makeOp(memLoad, operandPc, operandImm, 0, 0, 12'h004),
            makeOp(memStore, operandImm, operandPc, 0, 0, 12'h020));
        issuePair(makeOp(memLoad, operandReg, operandImm, 40, 0, 12'h000),
            makeOp(memStore, operandReg, operandReg, 7, 41, 12'h010));
        repeat (3) runCycle();

        testName = "stall";
        issuePair(makeOp(memLoad, operandReg, operandImm, 1, 0, 12'h100),
            makeOp(memStore, operandReg, operandReg, 2, 8, 12'h104));
        issuePair(makeOp(memStore, operandReg, operandReg, 3, 4, 12'h108),
            makeOp(memLoad, operandReg, operandImm, 5, 0, 12'h10c));
        stall = 1'b1;
        repeat (4) runCycle();
        stall = 1'b0;
        repeat (4) runCycle();

        // Clear hits one pair in register read and one entering issue
        testName = "clearFlush";
        issuePair(makeOp(memLoad, operandReg, operandImm, 1, 0, 12'h200),
            makeOp(memStore, operandReg, operandReg, 2, 3, 12'h204));
        runCycle();
        clear = 1'b1;
        issuePair(makeOp(memLoad, operandReg, operandImm, 4, 0, 12'h208),
            makeOp(memLoad, operandReg, operandImm, 5, 0, 12'h20c));
        issuePair(makeOp(memStore, operandReg, operandReg, 6, 7, 12'h210),
            makeOp(memLoad, operandReg, operandImm, 8, 0, 12'h214));
        runCycle();
        recovery.active = 1'b1;
        recovery.headPtr = rrModel[1].listPtr;
        recovery.tailPtr = rrModel[1].listPtr + 5'd1;
        repeat (4) runCycle();

        testName = "missRelease";
        loadOp = makeOp(memLoad, operandReg, operandImm, 1, 0, 12'h040);
        loadOp.hasMshr = 1'b1;
        loadOp.mshrId = 2'd2;
        storeOp = makeOp(memStore, operandReg, operandReg, 2, 3, 12'h044);
        storeOp.hasMshr = 1'b1;
        storeOp.mshrId = 2'd1;
        issuePair(loadOp, storeOp);
        runCycle();
        // Wrapping range over both lanes, only the load gives its entry back
        recovery.active = 1'b1;
        recovery.headPtr = rrModel[0].listPtr - 5'd20;
        recovery.tailPtr = rrModel[1].listPtr + 5'd1;
        #20;
        if (mshrRelease !== 4'b0100) begin
            reportMismatch(0, "mshrRelease", 4'b0100, mshrRelease);
        end
        runCycle();
        loadOp.mshrId = 2'd3;
        issuePair(loadOp, '0);
        runCycle();
        // Range just past the load, so it keeps its entry
        recovery.active = 1'b1;
        recovery.headPtr = rrModel[0].listPtr + 5'd1;
        recovery.tailPtr = rrModel[0].listPtr + 5'd4;
        repeat (4) runCycle();

        if (DUT.registerReadStage.rrChecks.failCount == 0) begin
            $display("test passed");
            $finish;
        end else begin
            $display("test failed");
            $fatal(1, "Bound assertions failed");
        end
    end

endmodule

/* tests/memRegisterReadStage_assertions.sv */
/*
 * Concurrent checks bound to the register-read stage.
 * Flush and stall kills, miss-entry release, quiet reset.
 */
`timescale 1ns/1ps

module memRegisterReadStage_assertions (
    input logic clk,
    input logic rstN,
    input logic stall,
    input memPipePkg::flushRange recovery,
    input memPipePkg::rrResult rrOut [memPipePkg::memIssueWidth],
    input logic [memPipePkg::mshrNum-1:0] mshrRelease
);
    import memPipePkg::*;

    int failCount = 0;
    logic [mshrNum-1:0] releaseMask;
    logic anyValid;

    // Head inclusive, tail exclusive, range may wrap past 31
    function automatic logic ptrCovered(flushRange flushIn, activeListPtr ptr);
        if (!flushIn.active) begin
            return 1'b0;
        end
        if (flushIn.headPtr <= flushIn.tailPtr) begin
            return ptr >= flushIn.headPtr && ptr < flushIn.tailPtr;
        end
        return ptr >= flushIn.headPtr || ptr < flushIn.tailPtr;
    endfunction

    // Entries owed back by flushed loads
    always_comb begin
        releaseMask = '0;
        anyValid = 1'b0;
        for (int i = 0; i < memIssueWidth; i++) begin
            anyValid = anyValid | rrOut[i].valid;
            if (rrOut[i].op.valid && rrOut[i].op.opKind == memLoad && rrOut[i].op.hasMshr &&
                    ptrCovered(recovery, rrOut[i].op.listPtr)) begin
                releaseMask[rrOut[i].op.mshrId] = 1'b1;
            end
        end
    end

    for (genvar i = 0; i < memIssueWidth; i++) begin : laneChecks
        flushKillsLane: assert property (@(posedge clk) disable iff (!rstN)
            ptrCovered(recovery, rrOut[i].op.listPtr) |-> !rrOut[i].valid)
        else begin
            failCount++;
            $error("Lane %0d left the stage inside the flush range", i);
        end

        stallKillsLane: assert property (@(posedge clk) disable iff (!rstN)
            stall |-> !rrOut[i].valid)
        else begin
            failCount++;
            $error("Lane %0d valid while stalled", i);
        end
    end

    releaseMatchesFlush: assert property (@(posedge clk) disable iff (!rstN)
        mshrRelease == releaseMask)
    else begin
        failCount++;
        $error("Miss entry release %b does not match flushed loads %b", mshrRelease, releaseMask);
    end

    quietAfterReset: assert property (@(posedge clk)
        (!rstN || $rose(rstN)) |-> (!anyValid && mshrRelease == '0))
    else begin
        failCount++;
        $error("Register-read stage active during or right after reset");
    end

endmodule
